/* build.f */
verilog/prefetch_pkg.sv
verilog/fetch_requester.sv
verilog/alignment_buffer.sv
verilog/issue_queue.sv
verilog/prefetch_top.sv
verification/prefetch_tb_mem.sv
verification/prefetch_chk.sv
verification/prefetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := prefetch_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard verilog/*.sv verification/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/prefetch_tb.sv */
module prefetch_tb;

  localparam int          CLK_PERIOD      = 8;
  localparam int          NUM_TESTS       = 6;
  localparam int          CYCLES_PER_TEST = 400;
  localparam logic [31:0] SEED            = 32'h7ab3_abd1;

  logic                 clk              = 1'b0;
  logic                 rst_n            = 1'b0;
  logic                 fetch_en         = 1'b1;
  logic                 branch_valid     = 1'b0;
  prefetch_pkg::addr_t  branch_addr      = '0;
  logic                 instr_ready      = 1'b1;
  logic                 ready_random     = 1'b0;
  logic [31:0]          rng_q            = SEED;
  logic                 busy;
  logic                 mem_req;
  logic                 mem_gnt;
  logic                 mem_rvalid;
  prefetch_pkg::addr_t  mem_addr;
  prefetch_pkg::word_t  mem_rdata;
  logic                 instr_valid;
  logic                 instr_compressed;
  prefetch_pkg::instr_t instr;
  prefetch_pkg::addr_t  instr_addr;

  // Expected decode stream position and transfers seen
  prefetch_pkg::addr_t  exp_addr  = '0;
  int                   delivered = 0;
  string                test_name = "reset_idle";

  always #(CLK_PERIOD / 2) clk = ~clk;

  prefetch_top #(
    .ISSUE_DEPTH (2)
  ) i_prefetch_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_en_i         (fetch_en),
    .branch_i           (branch_valid),
    .branch_addr_i      (branch_addr),
    .busy_o             (busy),
    .mem_req_o          (mem_req),
    .mem_addr_o         (mem_addr),
    .mem_gnt_i          (mem_gnt),
    .mem_rvalid_i       (mem_rvalid),
    .mem_rdata_i        (mem_rdata),
    .instr_valid_o      (instr_valid),
    .instr_ready_i      (instr_ready),
    .instr_o            (instr),
    .instr_addr_o       (instr_addr),
    .instr_compressed_o (instr_compressed)
  );

  instruction_mem_model i_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .rand_i       (rng_q),
    .mem_req_i    (mem_req),
    .mem_addr_i   (mem_addr),
    .mem_gnt_o    (mem_gnt),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [15:0] half_at(input prefetch_pkg::addr_t addr);
    prefetch_pkg::word_t w;
    w = i_mem.image[addr[9:2]];
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  // Expected {compressed, instruction} starting at a halfword address
  function automatic logic [32:0] expected_at(input prefetch_pkg::addr_t addr);
    logic [15:0] lo;
    logic [15:0] hi;
    lo = half_at(addr);
    hi = half_at(addr + 32'd2);
    if (lo[1:0] == prefetch_pkg::FULL_LEN_CODE) begin
      return {1'b0, hi, lo};
    end
    return {1'b1, 16'h0000, lo};
  endfunction

  // First odd-halfword target whose leading instruction has the wanted size
  function automatic prefetch_pkg::addr_t find_unaligned(input logic want_comp, input int start);
    prefetch_pkg::word_t w;
    int                  idx;
    for (int k = 0; k < 256; k++) begin
      idx = (start + k) % 256;
      w   = i_mem.image[idx];
      if ((w[17:16] != prefetch_pkg::FULL_LEN_CODE) == want_comp) begin
        return 32'(idx * 4 + 2);
      end
    end
    return 32'd2;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  // Called right after a rising edge
  task automatic jump_to(input prefetch_pkg::addr_t target);
    branch_valid <= 1'b1;
    branch_addr  <= target;
    @(posedge clk);
    branch_valid <= 1'b0;
  endtask

  task automatic wait_for_instrs(input int n);
    int target;
    target = delivered + n;
    while (delivered < target) begin
      @(posedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Random sources
  //////////////////////////////////////////////////////////////////////

  // Image with about half of the halfwords compressed
  initial begin : fill_image
    logic [31:0] s;
    logic [31:0] w;
    s = SEED;
    for (int i = 0; i < 256; i++) begin
      s        = lcg_next(s);
      w        = s;
      w[1:0]   = s[31] ? 2'b11 : {s[1], 1'b0};
      w[17:16] = s[30] ? 2'b11 : {s[17], 1'b0};
      i_mem.image[i] = w;
    end
  end

  always @(posedge clk) begin
    rng_q       <= lcg_next(rng_q);
    // Decode stalls about every other cycle when enabled
    instr_ready <= ready_random ? rng_q[27] : 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // Decode stream comparison
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : compare_decode
    logic [32:0] expected;
    if (rst_n) begin
      if (branch_valid) begin
        exp_addr = branch_addr;
      end else if (instr_valid && instr_ready) begin
        expected = expected_at(exp_addr);
        compare_value({test_name, " instr"}, expected[31:0], instr);
        compare_value({test_name, " addr"}, exp_addr, instr_addr);
        compare_value({test_name, " compressed"}, 32'(expected[32]), 32'(instr_compressed));
        exp_addr  = exp_addr + (expected[32] ? 32'd2 : 32'd4);
        delivered <= delivered + 1;
      end
    end
  end

  initial begin : watchdog
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    logic                req_prev;
    prefetch_pkg::addr_t target;
    int                  gap;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Nothing moves before the boot jump
    repeat (20) begin
      @(posedge clk);
      compare_value({test_name, " mem_req"}, 32'd0, 32'(mem_req));
      compare_value({test_name, " instr_valid"}, 32'd0, 32'(instr_valid));
      compare_value({test_name, " busy"}, 32'd0, 32'(busy));
    end

    test_name = "aligned_stream";
    jump_to(32'h0000_0100);
    // Target word goes out on the bus one cycle after the jump
    @(posedge clk);
    compare_value({test_name, " mem_req"}, 32'd1, 32'(mem_req));
    compare_value({test_name, " mem_addr"}, 32'h0000_0100, mem_addr);
    wait_for_instrs(40);

    test_name = "unaligned_compressed";
    jump_to(find_unaligned(1'b1, 10));
    wait_for_instrs(20);
    test_name = "unaligned_full";
    jump_to(find_unaligned(1'b0, 80));
    wait_for_instrs(20);

    test_name = "back_pressure";
    ready_random <= 1'b1;
    jump_to(32'h0000_0200);
    wait_for_instrs(150);

    // Branch right after a grant, its answer is still on the way
    test_name = "branch_in_flight";
    for (int b = 0; b < 12; b++) begin
      gap = int'(rng_q[26:24]);
      repeat (gap) @(posedge clk);
      while (!(mem_req && mem_gnt)) begin
        @(posedge clk);
      end
      target = {22'd0, rng_q[22:14], 1'b0};
      jump_to(target);
    end
    wait_for_instrs(20);

    test_name = "fetch_disable";
    ready_random <= 1'b0;
    fetch_en     <= 1'b0;
    @(posedge clk);
    req_prev = mem_req;
    while (busy) begin
      @(posedge clk);
      compare_value({test_name, " new request"}, 32'd0, 32'(mem_req && !req_prev));
      req_prev = mem_req;
    end
    // Idle means no answer is still on its way
    repeat (20) begin
      @(posedge clk);
      compare_value({test_name, " new request"}, 32'd0, 32'(mem_req && !req_prev));
      compare_value({test_name, " busy"}, 32'd0, 32'(busy));
      compare_value({test_name, " late response"}, 32'd0, 32'(mem_rvalid));
      req_prev = mem_req;
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* verification/prefetch_chk.sv */
module prefetch_chk (
  input logic                 clk,
  input logic                 rst_n,

  // Memory request channel
  input logic                 mem_req_i,
  input prefetch_pkg::addr_t  mem_addr_i,
  input logic                 mem_gnt_i,

  // Decode port and branch
  input logic                 branch_i,
  input logic                 instr_valid_i,
  input logic                 instr_ready_i,
  input prefetch_pkg::instr_t instr_i,
  input prefetch_pkg::addr_t  instr_addr_i,
  input logic                 instr_compressed_i,

  // Reads in flight inside the alignment buffer
  input logic [1:0]           outst_cnt_i
);

  // Request and address held until the grant
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i && !mem_gnt_i |=> mem_req_i && $stable(mem_addr_i))
    else $error("Bus request dropped or moved before its grant");

  // Stalled decode output stays put, only a branch may drop it
  decode_hold: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_i && !instr_ready_i && !branch_i |=>
      branch_i || (instr_valid_i && $stable(instr_i) &&
                   $stable(instr_addr_i) && $stable(instr_compressed_i)))
    else $error("Decode output changed while stalled");

  outst_limit: assert property (@(posedge clk) disable iff (!rst_n)
    outst_cnt_i <= 2'(prefetch_pkg::MAX_OUTSTANDING))
    else $error("Too many bus reads in flight");

endmodule

bind prefetch_top prefetch_chk i_prefetch_chk (
  .clk                (clk),
  .rst_n              (rst_n),
  .mem_req_i          (mem_req_o),
  .mem_addr_i         (mem_addr_o),
  .mem_gnt_i          (mem_gnt_i),
  .branch_i           (branch_i),
  .instr_valid_i      (instr_valid_o),
  .instr_ready_i      (instr_ready_i),
  .instr_i            (instr_o),
  .instr_addr_i       (instr_addr_o),
  .instr_compressed_i (instr_compressed_o),
  .outst_cnt_i        (i_alignment_buffer.outst_cnt_q)
);

/* verification/prefetch_tb_mem.sv */
module instruction_mem_model (
  input  logic                clk,
  input  logic                rst_n,

  // Random word from the testbench, new every cycle
  input  logic [31:0]         rand_i,

  // Instruction memory bus, slave side
  input  logic                mem_req_i,
  input  prefetch_pkg::addr_t mem_addr_i,
  output logic                mem_gnt_o,
  output logic                mem_rvalid_o,
  output prefetch_pkg::word_t mem_rdata_o
);

  // 1 KiB program image, the testbench fills and reads it directly
  prefetch_pkg::word_t image [256];

  // Granted reads waiting for their answer, oldest first
  prefetch_pkg::word_t data_q [$];
  int                  due_q  [$];
  int                  cycle;
  int                  last_due;

  always @(posedge clk or negedge rst_n) begin : bus_model
    int                  due;
    prefetch_pkg::word_t rdata;
    if (!rst_n) begin
      mem_gnt_o    <= 1'b0;
      mem_rvalid_o <= 1'b0;
      mem_rdata_o  <= '0;
      data_q.delete();
      due_q.delete();
      cycle    = 0;
      last_due = 0;
    end else begin
      cycle = cycle + 1;
      // Request taken at this edge, answer 1 to 3 cycles later
      if (mem_req_i && mem_gnt_o) begin
        due = cycle + ((rand_i[29:28] == 2'd3) ? 1 : int'(rand_i[29:28]) + 1);
        // Never overtake an older read
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        data_q.push_back(image[mem_addr_i[9:2]]);
        due_q.push_back(due);
      end
      // Grant about three cycles in four
      mem_gnt_o <= rand_i[31] | rand_i[30];
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        rdata = data_q.pop_front();
        void'(due_q.pop_front());
        mem_rvalid_o <= 1'b1;
        mem_rdata_o  <= rdata;
      end else begin
        mem_rvalid_o <= 1'b0;
      end
    end
  end

endmodule

/* verilog/prefetch_top.sv */
module prefetch_top #(
  parameter int unsigned ISSUE_DEPTH = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core control
  input  logic                 fetch_en_i,
  input  logic                 branch_i,
  input  prefetch_pkg::addr_t  branch_addr_i,
  output logic                 busy_o,

  // Instruction memory bus
  output logic                 mem_req_o,
  output prefetch_pkg::addr_t  mem_addr_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  prefetch_pkg::word_t  mem_rdata_i,

  // Decode port
  output logic                 instr_valid_o,
  input  logic                 instr_ready_i,
  output prefetch_pkg::instr_t instr_o,
  output prefetch_pkg::addr_t  instr_addr_o,
  output logic                 instr_compressed_o
);

  // Buffer to requester
  logic                 fetch_valid;
  logic                 fetch_ready;
  logic                 fetch_branch;
  prefetch_pkg::addr_t  fetch_branch_addr;

  // Buffer to issue queue
  logic                 aligned_valid;
  logic                 aligned_ready;
  prefetch_pkg::instr_t aligned_instr;
  prefetch_pkg::addr_t  aligned_addr;
  logic                 aligned_compressed;

  fetch_requester i_fetch_requester (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_valid_i       (fetch_valid),
    .fetch_ready_o       (fetch_ready),
    .fetch_branch_i      (fetch_branch),
    .fetch_branch_addr_i (fetch_branch_addr),
    .mem_req_o           (mem_req_o),
    .mem_addr_o          (mem_addr_o),
    .mem_gnt_i           (mem_gnt_i)
  );

  alignment_buffer i_alignment_buffer (
    .clk                  (clk),
    .rst_n                (rst_n),
    .branch_i             (branch_i),
    .branch_addr_i        (branch_addr_i),
    .fetch_en_i           (fetch_en_i),
    .busy_o               (busy_o),
    .fetch_valid_o        (fetch_valid),
    .fetch_ready_i        (fetch_ready),
    .fetch_branch_o       (fetch_branch),
    .fetch_branch_addr_o  (fetch_branch_addr),
    .resp_valid_i         (mem_rvalid_i),
    .resp_rdata_i         (mem_rdata_i),
    .aligned_valid_o      (aligned_valid),
    .aligned_ready_i      (aligned_ready),
    .aligned_instr_o      (aligned_instr),
    .aligned_addr_o       (aligned_addr),
    .aligned_compressed_o (aligned_compressed)
  );

  // The same branch pulse empties the queue
  issue_queue #(
    .ISSUE_DEPTH (ISSUE_DEPTH)
  ) i_issue_queue (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush_i         (branch_i),
    .wr_valid_i      (aligned_valid),
    .wr_ready_o      (aligned_ready),
    .wr_instr_i      (aligned_instr),
    .wr_addr_i       (aligned_addr),
    .wr_compressed_i (aligned_compressed),
    .rd_valid_o      (instr_valid_o),
    .rd_ready_i      (instr_ready_i),
    .rd_instr_o      (instr_o),
    .rd_addr_o       (instr_addr_o),
    .rd_compressed_o (instr_compressed_o)
  );

endmodule

/* verilog/issue_queue.sv */
module issue_queue #(
  parameter int unsigned ISSUE_DEPTH = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush_i,

  // Write side from the alignment buffer
  input  logic                 wr_valid_i,
  output logic                 wr_ready_o,
  input  prefetch_pkg::instr_t wr_instr_i,
  input  prefetch_pkg::addr_t  wr_addr_i,
  input  logic                 wr_compressed_i,

  // Read side to decode
  output logic                 rd_valid_o,
  input  logic                 rd_ready_i,
  output prefetch_pkg::instr_t rd_instr_o,
  output prefetch_pkg::addr_t  rd_addr_o,
  output logic                 rd_compressed_o
);

  localparam int unsigned PTR_W = (ISSUE_DEPTH > 1) ? $clog2(ISSUE_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(ISSUE_DEPTH + 1);

  prefetch_pkg::instr_t instr_mem [ISSUE_DEPTH];
  prefetch_pkg::addr_t  addr_mem  [ISSUE_DEPTH];
  logic                 comp_mem  [ISSUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push, pop;

  // Circular pointer step
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(ISSUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign wr_ready_o = count_q != CNT_W'(ISSUE_DEPTH);
  // Head is hidden in the flush cycle
  assign rd_valid_o = (count_q != '0) && !flush_i;

  assign push = wr_valid_i && wr_ready_o && !flush_i;
  assign pop  = rd_valid_o && rd_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Compressed entries get a zero upper half
  always_ff @(posedge clk) begin
    if (push) begin
      instr_mem[wr_ptr_q] <= wr_compressed_i ? {16'h0000, wr_instr_i[15:0]} : wr_instr_i;
      addr_mem[wr_ptr_q]  <= wr_addr_i;
      comp_mem[wr_ptr_q]  <= wr_compressed_i;
    end
  end

  assign rd_instr_o      = instr_mem[rd_ptr_q];
  assign rd_addr_o       = addr_mem[rd_ptr_q];
  assign rd_compressed_o = comp_mem[rd_ptr_q];

endmodule

/* verilog/alignment_buffer.sv */
module alignment_buffer (
  input  logic                 clk,
  input  logic                 rst_n,

  // Branch and enable from the core
  input  logic                 branch_i,
  input  prefetch_pkg::addr_t  branch_addr_i,
  input  logic                 fetch_en_i,
  output logic                 busy_o,

  // Fetch strobe to the requester
  output logic                 fetch_valid_o,
  input  logic                 fetch_ready_i,
  output logic                 fetch_branch_o,
  output prefetch_pkg::addr_t  fetch_branch_addr_o,

  // Bus responses, in order
  input  logic                 resp_valid_i,
  input  prefetch_pkg::word_t  resp_rdata_i,

  // Aligned instructions to the issue queue
  output logic                 aligned_valid_o,
  input  logic                 aligned_ready_i,
  output prefetch_pkg::instr_t aligned_instr_o,
  output prefetch_pkg::addr_t  aligned_addr_o,
  output logic                 aligned_compressed_o
);

  localparam int unsigned DEPTH = prefetch_pkg::MAX_OUTSTANDING + 1;

  // Word buffer, entry 0 feeds the output
  prefetch_pkg::word_t [DEPTH-1:0] rdata_q, rdata_int, rdata_n;
  logic [DEPTH-1:0]                valid_q, valid_int, valid_n;

  // Complete instructions held, up to two per word
  logic [2:0] instr_cnt_q, instr_cnt_n;
  logic [1:0] outst_cnt_q, outst_cnt_n;
  logic [1:0] n_flush_q, n_flush_n, n_flush_branch;
  logic [1:0] n_incoming;

  // Parse position of the next incoming word
  logic aligned_q, aligned_n;
  logic complete_q, complete_n;

  // No fetching before the first branch
  logic started_q;

  prefetch_pkg::addr_t  addr_q, addr_n, addr_incr;
  prefetch_pkg::instr_t instr_cur, instr_unaligned;
  logic                 valid_cur, valid_unaligned_full;
  logic                 aligned_is_comp, unaligned_is_comp;
  logic                 resp_valid_gated, fetch_accept, pop, shift_en;

  // Stale words are swallowed while the flush count runs down
  assign resp_valid_gated = (n_flush_q == 2'd0) && resp_valid_i;

  //////////////////////////////////////////////////////////////////////
  // Fetch control
  //////////////////////////////////////////////////////////////////////

  assign fetch_valid_o = fetch_en_i &&
                         (outst_cnt_q < 2'(prefetch_pkg::MAX_OUTSTANDING)) &&
                         (branch_i ||
                          (started_q && ((instr_cnt_q == 3'd0) ||
                                         (instr_cnt_q == 3'd1 && outst_cnt_q == 2'd0))));

  assign busy_o       = (outst_cnt_q != 2'd0) || fetch_valid_o;
  assign fetch_accept = fetch_valid_o && fetch_ready_i;

  // Requester works on whole words
  assign fetch_branch_o      = branch_i;
  assign fetch_branch_addr_o = {branch_addr_i[31:2], 2'b00};

  //////////////////////////////////////////////////////////////////////
  // Instruction assembly
  //////////////////////////////////////////////////////////////////////

  // Aligned form sits in entry 0 or the incoming word
  assign instr_cur = valid_q[0] ? rdata_q[0] : resp_rdata_i;

  // Unaligned form spans the upper half and the following word
  assign instr_unaligned = valid_q[1] ? {rdata_q[1][15:0], instr_cur[31:16]}
                                      : {resp_rdata_i[15:0], instr_cur[31:16]};

  assign valid_cur            = valid_q[0] || resp_valid_gated;
  assign valid_unaligned_full = valid_q[1] || (valid_q[0] && resp_valid_gated);

  assign aligned_is_comp   = instr_cur[1:0] != prefetch_pkg::FULL_LEN_CODE;
  assign unaligned_is_comp = instr_cur[17:16] != prefetch_pkg::FULL_LEN_CODE;

  always_comb begin
    aligned_instr_o      = instr_cur;
    aligned_compressed_o = aligned_is_comp;
    aligned_valid_o      = valid_cur;
    if (addr_q[1]) begin
      aligned_instr_o      = instr_unaligned;
      aligned_compressed_o = unaligned_is_comp;
      // 32-bit needs the next word too
      aligned_valid_o      = unaligned_is_comp ? valid_cur : valid_unaligned_full;
    end
    // Whatever is offered belongs to the old path
    if (branch_i) begin
      aligned_valid_o = 1'b0;
    end
  end

  assign aligned_addr_o = addr_q;
  assign pop            = aligned_valid_o && aligned_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Buffer update
  //////////////////////////////////////////////////////////////////////

  // Incoming word goes to the first free entry
  always_comb begin
    logic placed;
    placed    = 1'b0;
    rdata_int = rdata_q;
    valid_int = valid_q;
    for (int j = 0; j < DEPTH; j++) begin
      if (resp_valid_gated && !placed && !valid_q[j]) begin
        rdata_int[j] = resp_rdata_i;
        valid_int[j] = 1'b1;
        placed       = 1'b1;
      end
    end
  end

  assign addr_incr = {addr_q[31:2], 2'b00} +
                     prefetch_pkg::addr_t'(prefetch_pkg::WORD_BYTES);

  // Next address and whether entry 0 is used up
  always_comb begin
    addr_n   = addr_q;
    shift_en = 1'b0;
    if (pop) begin
      if (addr_q[1]) begin
        // Upper half consumed, entry 0 is done either way
        addr_n   = {addr_incr[31:2], unaligned_is_comp ? 2'b00 : 2'b10};
        shift_en = 1'b1;
      end else if (aligned_is_comp) begin
        addr_n = {addr_q[31:2], 2'b10};
      end else begin
        addr_n   = addr_incr;
        shift_en = 1'b1;
      end
    end
  end

  always_comb begin
    rdata_n = rdata_int;
    valid_n = valid_int;
    if (shift_en) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        rdata_n[i] = rdata_int[i+1];
      end
      valid_n = valid_int >> 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  // Complete instructions in each new word, from the parse state
  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_incoming = 2'd0;
    if (branch_i) begin
      // Unaligned target skips the lower half of its first word
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_valid_gated) begin
      if (aligned_q && resp_rdata_i[1:0] == prefetch_pkg::FULL_LEN_CODE) begin
        n_incoming = 2'd1;
      end else if (!aligned_q && complete_q) begin
        // First word after an unaligned branch
        n_incoming = (resp_rdata_i[17:16] == prefetch_pkg::FULL_LEN_CODE) ? 2'd0 : 2'd1;
      end else begin
        // Lower half closes an instruction, upper half decides the rest
        n_incoming = (resp_rdata_i[17:16] == prefetch_pkg::FULL_LEN_CODE) ? 2'd1 : 2'd2;
      end
      if (!aligned_q || resp_rdata_i[1:0] != prefetch_pkg::FULL_LEN_CODE) begin
        aligned_n  = resp_rdata_i[17:16] != prefetch_pkg::FULL_LEN_CODE;
        complete_n = aligned_n;
      end
    end
  end

  always_comb begin
    instr_cnt_n = instr_cnt_q + {1'b0, n_incoming} - {2'b00, pop};
    if (branch_i) begin
      instr_cnt_n = 3'd0;
    end
  end

  assign outst_cnt_n = outst_cnt_q + {1'b0, fetch_accept} - {1'b0, resp_valid_i};

  // Everything in flight at the branch is stale
  assign n_flush_branch = outst_cnt_q - {1'b0, resp_valid_i};

  always_comb begin
    n_flush_n = n_flush_q;
    if (branch_i) begin
      n_flush_n = n_flush_branch;
    end else if (resp_valid_i && n_flush_q != 2'd0) begin
      n_flush_n = n_flush_q - 2'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q      <= '0;
      valid_q     <= '0;
      started_q   <= 1'b0;
      aligned_q   <= 1'b0;
      complete_q  <= 1'b0;
      instr_cnt_q <= 3'd0;
      outst_cnt_q <= 2'd0;
      n_flush_q   <= 2'd0;
    end else begin
      if (branch_i) begin
        valid_q   <= '0;
        addr_q    <= branch_addr_i;
        started_q <= 1'b1;
      end else begin
        valid_q <= valid_n;
        addr_q  <= addr_n;
      end
      aligned_q   <= aligned_n;
      complete_q  <= complete_n;
      instr_cnt_q <= instr_cnt_n;
      outst_cnt_q <= outst_cnt_n;
      n_flush_q   <= n_flush_n;
    end
  end

  // Word contents, qualified by valid_q
  always_ff @(posedge clk) begin
    rdata_q <= rdata_n;
  end

endmodule

/* verilog/fetch_requester.sv */
module fetch_requester (
  input  logic                clk,
  input  logic                rst_n,

  // Fetch strobe from the alignment buffer
  input  logic                fetch_valid_i,
  output logic                fetch_ready_o,
  input  logic                fetch_branch_i,
  input  prefetch_pkg::addr_t fetch_branch_addr_i,

  // Instruction memory request channel
  output logic                mem_req_o,
  output prefetch_pkg::addr_t mem_addr_o,
  input  logic                mem_gnt_i
);

  // A request is waiting for its grant
  logic                pending_q;

  // Address currently on the bus
  prefetch_pkg::addr_t req_addr_q;

  // Word address of the next sequential fetch
  prefetch_pkg::addr_t next_addr_q;

  prefetch_pkg::addr_t fetch_addr;
  logic                fetch_accept;

  // Free when idle, or when the waiting request leaves this cycle
  assign fetch_ready_o = !pending_q || mem_gnt_i;
  assign fetch_accept  = fetch_valid_i && fetch_ready_o;

  // Branch target wins over the sequential address
  assign fetch_addr = fetch_branch_i ? fetch_branch_addr_i : next_addr_q;

  //////////////////////////////////////////////////////////////////////
  // Request state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q   <= 1'b0;
      next_addr_q <= '0;
    end else begin
      if (fetch_accept) begin
        pending_q   <= 1'b1;
        next_addr_q <= fetch_addr + prefetch_pkg::addr_t'(prefetch_pkg::WORD_BYTES);
      end else begin
        // Granted and nothing new behind it
        if (mem_gnt_i) begin
          pending_q <= 1'b0;
        end
        // Keep a target that could not be fetched right away
        if (fetch_branch_i) begin
          next_addr_q <= fetch_branch_addr_i;
        end
      end
    end
  end

  // Bus address only moves on a new fetch, so it holds until granted
  always_ff @(posedge clk) begin
    if (fetch_accept) begin
      req_addr_q <= fetch_addr;
    end
  end

  assign mem_req_o  = pending_q;
  assign mem_addr_o = req_addr_q;

endmodule

/* verilog/prefetch_pkg.sv */
package prefetch_pkg;

  // Byte address of an instruction or of a bus word
  typedef logic [31:0] addr_t;

  // One data word as returned by the instruction bus
  typedef logic [31:0] word_t;

  // Instruction handed to decode
  // Compressed ones carry zeros in the upper half
  typedef logic [31:0] instr_t;

  //////////////////////////////////////////////////////////////////////
  // RISC-V length decoding
  //////////////////////////////////////////////////////////////////////

  // Low two bits of a 32-bit instruction
  // Every other value starts a 16-bit one
  localparam logic [1:0] FULL_LEN_CODE = 2'b11;

  // Bus geometry
  localparam int unsigned WORD_BYTES = 4;

  // Reads that may be in flight at once
  // The alignment buffer is sized as this plus one word
  localparam int unsigned MAX_OUTSTANDING = 2;

endpackage
